// ==== common/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ************************************************
// cache geometry
// ************************************************

`define CACHE_LINES     32 // direct mapped, one way
`define WORDS_PER_LINE  8  // 16 bytes per line
`define OFFSET_BITS     4  // byte offset inside a line
`define INDEX_BITS      5  // selects one of the lines
`define TAG_BITS        7  // whatever is left of the 16-bit address

// ************************************************
// backing memory
// ************************************************

// read latency in cycles from mem_read to memory_data_valid
`define MEM_LATENCY     4

`endif

// ==== common/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

	// ************************************************
	// address and data vectors
	// ************************************************

	typedef logic [15:0] addr_t; // byte address as seen by the processor
	typedef logic [15:0] word_t; // one data word, two bytes

	// an address splits into tag, index and offset from the top down
	typedef logic [`TAG_BITS-1:0] tag_t;
	typedef logic [`INDEX_BITS-1:0] index_t;
	typedef logic [`OFFSET_BITS-1:0] offset_t; // bit 0 stays clear for word accesses

	// ************************************************
	// miss fill controller
	// ************************************************

	// FILL_IDLE waits for a load miss
	// FILL_BUSY issues the eight reads and collects the returning words
	// FILL_TAG writes tag and valid once the last word is in the data array
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_BUSY,
		FILL_TAG
	} fill_state_t;

endpackage

// ==== cache/cache_tag_array.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_tag_array (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t req_addr, // lookup address
	input  logic             write_tag_array, // fill finished, make the line valid
	input  cache_pkg::addr_t base_addr, // line that was just filled
	output logic             hit,
	output logic             miss_detected // only loads can miss, stores never allocate
);

	localparam int TAG_LSB = `OFFSET_BITS + `INDEX_BITS;

	logic [`CACHE_LINES-1:0] valid_q; // one bit per line
	cache_pkg::tag_t         tag_mem [`CACHE_LINES];

	cache_pkg::index_t req_index;
	cache_pkg::tag_t   req_tag;
	cache_pkg::index_t fill_index;
	cache_pkg::tag_t   fill_tag;

	// split both addresses into index and tag
	assign req_index  = req_addr[`OFFSET_BITS +: `INDEX_BITS];
	assign req_tag    = req_addr[TAG_LSB +: `TAG_BITS];
	assign fill_index = base_addr[`OFFSET_BITS +: `INDEX_BITS];
	assign fill_tag   = base_addr[TAG_LSB +: `TAG_BITS];

	// ************************************************
	// lookup
	// ************************************************

	assign hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

	// a store that misses goes straight to memory and never starts a fill
	assign miss_detected = req_valid && !req_write && !hit;

	// ************************************************
	// update
	// ************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0; // every line starts out empty
		end else if (write_tag_array) begin
			valid_q[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write_tag_array) begin
			tag_mem[fill_index] <= fill_tag; // the old tag at this index is simply replaced
		end
	end

endmodule

// ==== cache/cache_data_array.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_data_array (
	input  logic               clk,
	input  logic               wen, // one word per cycle, fill or store hit
	input  cache_pkg::index_t  windex,
	input  cache_pkg::offset_t woffset, // byte offset, bit 0 ignored
	input  cache_pkg::word_t   wdata,
	input  cache_pkg::addr_t   raddr, // full request address
	output cache_pkg::word_t   rword
);

	localparam int DEPTH = `CACHE_LINES * `WORDS_PER_LINE;
	localparam int AW    = $clog2(DEPTH); // index bits plus word select bits

	cache_pkg::word_t data_mem [DEPTH];

	logic [AW-1:0] waddr;
	logic [AW-1:0] raddr_word;

	// ************************************************
	// word addressing
	// ************************************************

	// line index on top, word within the line below, byte bit dropped
	assign waddr      = {windex, woffset[`OFFSET_BITS-1:1]};
	assign raddr_word = raddr[`OFFSET_BITS+`INDEX_BITS-1:1];

	always_ff @(posedge clk) begin
		if (wen) begin
			data_mem[waddr] <= wdata;
		end
	end

	// read is asynchronous so a hit load can be registered in the same cycle
	assign rword = data_mem[raddr_word];

endmodule

// ==== cache/cache_fill_fsm.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_fill_fsm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              miss_detected, // load lookup missed this cycle
	input  cache_pkg::addr_t  req_addr, // address of the stalled load
	input  logic              memory_data_valid, // a fill word is on mem_rdata
	output logic              stall, // holds the requester
	output logic              fsm_busy, // high for the whole fill
	output logic              mem_read, // one read per cycle until the line is requested
	output cache_pkg::addr_t  mem_read_addr,
	output logic              write_data_array, // fill word goes into the data array
	output cache_pkg::offset_t cache_write_block_offset,
	output logic              write_tag_array, // one cycle pulse after the last word
	output cache_pkg::addr_t  base_addr // line aligned miss address
);

	localparam int AW = $bits(cache_pkg::addr_t);

	cache_pkg::fill_state_t state_q;
	cache_pkg::addr_t       base_q;
	cache_pkg::offset_t     rd_off_q; // offset of the next read to issue
	cache_pkg::offset_t     wr_off_q; // offset of the next word to land
	logic                   read_done_q; // all eight reads have gone out

	// one extra bit on top catches the wrap past the last word of the line
	logic [`OFFSET_BITS:0]  rd_sum;
	logic [`OFFSET_BITS:0]  wr_sum;

	assign rd_sum = {1'b0, rd_off_q} + (`OFFSET_BITS+1)'(2);
	assign wr_sum = {1'b0, wr_off_q} + (`OFFSET_BITS+1)'(2);

	// ************************************************
	// outputs
	// ************************************************

	assign fsm_busy = (state_q != cache_pkg::FILL_IDLE);

	// a fresh miss stalls in the same cycle, before the FSM has left idle
	assign stall = miss_detected | fsm_busy;

	assign mem_read = (state_q == cache_pkg::FILL_BUSY) && !read_done_q;
	assign mem_read_addr = base_q + AW'(rd_off_q); // base is aligned so this never carries

	// memory only returns data for reads issued by this FSM
	assign write_data_array = (state_q == cache_pkg::FILL_BUSY) && memory_data_valid;
	assign cache_write_block_offset = wr_off_q;

	assign write_tag_array = (state_q == cache_pkg::FILL_TAG);
	assign base_addr = base_q;

	// ************************************************
	// state and offset counters
	// ************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= cache_pkg::FILL_IDLE;
			rd_off_q    <= '0;
			wr_off_q    <= '0;
			read_done_q <= 1'b0;
		end else begin
			case (state_q)
				cache_pkg::FILL_IDLE: begin
					if (miss_detected) begin
						state_q <= cache_pkg::FILL_BUSY; // base_q is captured alongside
					end
				end
				cache_pkg::FILL_BUSY: begin
					// the read side runs ahead of the write side by the memory latency
					if (mem_read) begin
						rd_off_q <= rd_sum[`OFFSET_BITS-1:0];
						if (rd_sum[`OFFSET_BITS]) begin
							read_done_q <= 1'b1; // last read issued, stop requesting
						end
					end
					if (write_data_array) begin
						wr_off_q <= wr_sum[`OFFSET_BITS-1:0];
						if (wr_sum[`OFFSET_BITS]) begin
							state_q <= cache_pkg::FILL_TAG; // eighth word just landed
						end
					end
				end
				cache_pkg::FILL_TAG: begin
					// tag goes in this cycle so the retried load hits next cycle
					rd_off_q    <= '0;
					wr_off_q    <= '0;
					read_done_q <= 1'b0;
					state_q     <= cache_pkg::FILL_IDLE;
				end
				default: begin
					state_q <= cache_pkg::FILL_IDLE;
				end
			endcase
		end
	end

	// the miss address is only taken when a new fill starts
	always_ff @(posedge clk) begin
		if ((state_q == cache_pkg::FILL_IDLE) && miss_detected) begin
			base_q <= {req_addr[AW-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
		end
	end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  logic               req_write,
	input  cache_pkg::addr_t   req_addr,
	input  cache_pkg::word_t   req_wdata,
	input  logic               stall, // from the fill FSM
	input  logic               hit, // lookup result for req_addr
	input  logic               write_data_array, // fill word is present this cycle
	input  cache_pkg::addr_t   base_addr,
	input  cache_pkg::offset_t cache_write_block_offset,
	input  cache_pkg::word_t   mem_rdata, // returning fill word
	input  cache_pkg::word_t   rword, // cached word at req_addr
	output logic               dwen,
	output cache_pkg::index_t  dindex,
	output cache_pkg::offset_t doffset,
	output cache_pkg::word_t   dwdata,
	output logic               mem_write,
	output cache_pkg::addr_t   mem_write_addr,
	output cache_pkg::word_t   mem_write_data,
	output cache_pkg::word_t   rdata,
	output logic               rdata_valid
);

	logic accept; // request taken this cycle
	logic load_accept;
	logic store_hit;

	assign accept      = req_valid && !stall;
	assign load_accept = accept && !req_write; // accepted loads always hit
	assign store_hit   = accept && req_write && hit;

	// ************************************************
	// write through to memory
	// ************************************************

	// every accepted store reaches memory whether it hit or not
	assign mem_write      = accept && req_write;
	assign mem_write_addr = req_addr;
	assign mem_write_data = req_wdata;

	// ************************************************
	// data array write port
	// ************************************************

	// stores are held off during a fill so the two sources never collide
	assign dwen    = write_data_array || store_hit;
	assign dindex  = write_data_array ? base_addr[`OFFSET_BITS +: `INDEX_BITS]
	                                  : req_addr[`OFFSET_BITS +: `INDEX_BITS];
	assign doffset = write_data_array ? cache_write_block_offset
	                                  : req_addr[`OFFSET_BITS-1:0];
	assign dwdata  = write_data_array ? mem_rdata : req_wdata;

	// ************************************************
	// load response
	// ************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= load_accept; // exactly one cycle after acceptance
		end
	end

	always_ff @(posedge clk) begin
		if (load_accept) begin
			rdata <= rword; // holds the last load value until the next load
		end
	end

endmodule

// ==== logic/mem_pipe.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module mem_pipe #(
	parameter int LATENCY = `MEM_LATENCY // cycles from read issue to data, at least 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_read,
	input  cache_pkg::addr_t mem_read_addr,
	input  logic             mem_write, // completes in one cycle
	input  cache_pkg::addr_t mem_write_addr,
	input  cache_pkg::word_t mem_write_data,
	output cache_pkg::word_t mem_rdata,
	output logic             memory_data_valid
);

	localparam int AW    = $bits(cache_pkg::addr_t);
	localparam int DEPTH = 1 << (AW - 1); // 64 KiB of bytes, held as words

	// contents start at zero so the first load to any address reads zero
	cache_pkg::word_t mem_array [DEPTH] = '{default: '0};

	// stage 0 is loaded at issue, stage LATENCY-1 drives the outputs
	logic [LATENCY-1:0] pipe_vld;
	cache_pkg::word_t   pipe_data [LATENCY];

	// ************************************************
	// read pipeline
	// ************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe_vld <= '0; // drops any reads in flight
		end else begin
			pipe_vld[0] <= mem_read;
			for (int i = 1; i < LATENCY; i++) begin
				pipe_vld[i] <= pipe_vld[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		pipe_data[0] <= mem_array[mem_read_addr[AW-1:1]]; // storage is read when the read issues
		for (int i = 1; i < LATENCY; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	assign mem_rdata         = pipe_data[LATENCY-1];
	assign memory_data_valid = pipe_vld[LATENCY-1];

	// ************************************************
	// write port
	// ************************************************

	always_ff @(posedge clk) begin
		if (mem_write) begin
			mem_array[mem_write_addr[AW-1:1]] <= mem_write_data;
		end
	end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_valid,
	input  logic             req_write, // 1 for store, 0 for load
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	output logic             stall,
	output cache_pkg::word_t rdata,
	output logic             rdata_valid
);

	// lookup and fill control
	logic               hit;
	logic               miss_detected;
	logic               write_data_array;
	logic               write_tag_array;
	cache_pkg::offset_t cache_write_block_offset;
	cache_pkg::addr_t   base_addr;

	// data array port
	logic               dwen;
	cache_pkg::index_t  dindex;
	cache_pkg::offset_t doffset;
	cache_pkg::word_t   dwdata;
	cache_pkg::word_t   rword;

	// backing memory
	logic               mem_read;
	cache_pkg::addr_t   mem_read_addr;
	logic               mem_write;
	cache_pkg::addr_t   mem_write_addr;
	cache_pkg::word_t   mem_write_data;
	cache_pkg::word_t   mem_rdata;
	logic               memory_data_valid;

	// ************************************************
	// cache
	// ************************************************

	cache_tag_array tag_array_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.write_tag_array(write_tag_array), .base_addr(base_addr),
		.hit(hit), .miss_detected(miss_detected)
	);

	cache_fill_fsm fill_fsm_i (
		.clk(clk), .rst_n(rst_n),
		.miss_detected(miss_detected), .req_addr(req_addr),
		.memory_data_valid(memory_data_valid),
		.stall(stall), .fsm_busy(),
		.mem_read(mem_read), .mem_read_addr(mem_read_addr),
		.write_data_array(write_data_array),
		.cache_write_block_offset(cache_write_block_offset),
		.write_tag_array(write_tag_array), .base_addr(base_addr)
	);

	cache_data_array data_array_i (
		.clk(clk), .wen(dwen), .windex(dindex), .woffset(doffset), .wdata(dwdata),
		.raddr(req_addr), .rword(rword)
	);

	cache_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.stall(stall), .hit(hit), .write_data_array(write_data_array),
		.base_addr(base_addr), .cache_write_block_offset(cache_write_block_offset),
		.mem_rdata(mem_rdata), .rword(rword),
		.dwen(dwen), .dindex(dindex), .doffset(doffset), .dwdata(dwdata),
		.mem_write(mem_write), .mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.rdata(rdata), .rdata_valid(rdata_valid)
	);

	// ************************************************
	// memory
	// ************************************************

	mem_pipe mem_pipe_i (
		.clk(clk), .rst_n(rst_n),
		.mem_read(mem_read), .mem_read_addr(mem_read_addr),
		.mem_write(mem_write), .mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_rdata(mem_rdata), .memory_data_valid(memory_data_valid)
	);

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module dcache_tb;

	localparam int NUM_OPS      = 2000; // random requests after the directed part
	localparam int DIRECTED_OPS = 64; // generous count for the directed requests
	localparam int LATENCY      = `MEM_LATENCY; // the DUT uses the default latency
	localparam int STALL_LIMIT  = LATENCY + 16; // cycles one request may wait
	localparam logic [15:0] ADDR_MASK = 16'h07fe; // four tags over all indices, word aligned
	localparam logic [31:0] SEED      = 32'h4a72;
	localparam longint WATCHDOG_NS = longint'(NUM_OPS + DIRECTED_OPS) * (LATENCY + 16) * 4;

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	logic        req_write;
	logic [15:0] req_addr;
	logic [15:0] req_wdata;
	logic        stall;
	logic [15:0] rdata;
	logic        rdata_valid;

	logic [15:0] model_mem [1024]; // one word per even address in the window
	logic [31:0] lfsr_state;
	logic        load_pending; // a load was accepted in the previous cycle
	logic [15:0] expected_q; // model word for that load
	logic [15:0] expected_addr;
	string       test_name;
	int          errors;
	int          loads_checked;

	dcache_top dcache_top_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.stall(stall), .rdata(rdata), .rdata_valid(rdata_valid)
	);

	always #2 clk = ~clk; // 4 ns period

	// ************************************************
	// random numbers
	// ************************************************

	// taps 32, 22, 2 and 1, shifting toward the top
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit, the new bit enters at the bottom of the result
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// ************************************************
	// request driving
	// ************************************************

	// entered 1 ns after a rising edge, leaves 1 ns after the edge that took the request
	task automatic issue(input logic wr, input logic [15:0] addr, input logic [15:0] data);
		int waited;
		waited = 0;
		req_valid = 1'b1;
		req_write = wr;
		req_addr  = addr & ADDR_MASK;
		req_wdata = data;
		@(negedge clk);
		while (stall) begin
			waited++;
			if (waited > STALL_LIMIT) begin
				$display("stall held for more than %0d cycles at addr %h", STALL_LIMIT, addr);
				errors++;
				break;
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0; // the next issue may raise it again right away
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
	endtask

	// byte address from tag, line index and word number
	function automatic logic [15:0] line_addr(input int tag, input int index, input int word);
		return 16'((tag << 9) | (index << 4) | (word << 1));
	endfunction

	// ************************************************
	// response monitor and reference model
	// ************************************************

	always @(negedge clk) begin
		if (!rst_n) begin
			load_pending = 1'b0;
		end else begin
			// response for the load taken one cycle ago
			if (rdata_valid && !load_pending) begin
				$display("rdata_valid rose without an accepted load in %s", test_name);
				errors++;
			end else if (!rdata_valid && load_pending) begin
				$display("no rdata_valid one cycle after the load to %h in %s",
					expected_addr, test_name);
				errors++;
			end else if (load_pending && rdata !== expected_q) begin
				$display("CHECK FAILED %s addr %h expected %h actual %h",
					test_name, expected_addr, expected_q, rdata);
				errors++;
			end
			if (load_pending) loads_checked++;
			// stall is settled here, so acceptance at the coming edge is known
			load_pending = req_valid && !req_write && !stall;
			if (load_pending) begin
				expected_q    = model_mem[req_addr[10:1]];
				expected_addr = req_addr;
			end
			if (req_valid && req_write && !stall) begin
				model_mem[req_addr[10:1]] = req_wdata; // write-through reaches memory
			end
		end
	end

	// ************************************************
	// test sequence
	// ************************************************

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		lfsr_state = SEED;
		errors = 0;
		loads_checked = 0;
		test_name = "reset";
		for (int i = 0; i < 1024; i++) model_mem[i] = '0; // memory starts cleared
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		@(negedge clk); // outputs quiet with no request presented
		if (stall !== 1'b0) begin
			$display("CHECK FAILED %s stall expected 0 actual %b", test_name, stall);
			errors++;
		end
		if (rdata_valid !== 1'b0) begin
			$display("CHECK FAILED %s rdata_valid expected 0 actual %b", test_name, rdata_valid);
			errors++;
		end
		idle_cycle();

		// first loads see the cleared memory after a fill
		test_name = "first_load";
		issue(1'b0, line_addr(2, 16, 3), 16'h0);
		issue(1'b0, line_addr(2, 16, 0), 16'h0);

		// two lines that share index 5, every word written through
		test_name = "conflict_fill";
		for (int w = 0; w < 8; w++) begin
			issue(1'b1, line_addr(0, 5, w), 16'(16'h1100 + w));
			issue(1'b1, line_addr(1, 5, w), 16'(16'h2200 + w));
		end
		// each load evicts the other line and refills all eight words
		for (int w = 0; w < 8; w++) begin
			issue(1'b0, line_addr(0, 5, w), 16'h0);
			issue(1'b0, line_addr(1, 5, w), 16'h0);
		end

		// store miss leaves the cache alone, the load then fills from memory
		test_name = "store_miss";
		issue(1'b1, line_addr(3, 9, 6), 16'hbeef);
		issue(1'b0, line_addr(3, 9, 6), 16'h0);
		// the line is resident now, so this store updates the cached word too
		test_name = "store_hit";
		issue(1'b1, line_addr(3, 9, 6), 16'hcafe);
		issue(1'b0, line_addr(3, 9, 6), 16'h0);
		issue(1'b1, line_addr(3, 9, 1), 16'h5a5a);
		issue(1'b0, line_addr(3, 9, 1), 16'h0);

		// random loads and stores with the odd idle cycle
		test_name = "random_mix";
		for (int i = 0; i < NUM_OPS; i++) begin
			logic        wr;
			logic [15:0] addr;
			logic [15:0] data;
			wr   = (rand_bits(1) != 16'd0);
			addr = rand_bits(10) << 1;
			data = rand_bits(16);
			issue(wr, addr, data);
			if (rand_bits(2) == 16'd0) idle_cycle();
		end

		repeat (3) idle_cycle(); // lets the monitor see the last response
		if (loads_checked == 0) begin
			$display("no load responses were observed at all");
			errors++;
		end
		$display("errors %0d, loads checked %0d", errors, loads_checked);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// bound is the worst case of every request waiting a full fill plus margin
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
common/cache_pkg.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_fill_fsm.sv
logic/cache_ctrl.sv
logic/mem_pipe.sv
logic/dcache_top.sv
tests/dcache_tb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' verilog.f)
HEADERS := common/cache_macros.svh

.PHONY: all run clean

all: obj_dir/Vdcache_tb

# rebuilt only when a source, the header or the file list changes
obj_dir/Vdcache_tb: verilog.f $(SOURCES) $(HEADERS)
	verilator --binary -j 0 -f verilog.f --top-module dcache_tb -o Vdcache_tb

# prints the simulation output and fails unless the pass message shows up
run: obj_dir/Vdcache_tb
	@out="$$(./obj_dir/Vdcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
